/* compile.f */
src/enemy_pkg.sv
src/vga_if.sv
src/enemy_ctl.sv
src/hit_detect.sv
src/enemy_missile_ctl.sv
src/sprite_draw.sv
src/enemy_unit.sv
verification/enemy_unit_tb.sv

/* run_sim.sh */
#!/bin/bash
# build and run the enemy unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module enemy_unit_tb \
  -o sim_enemy_unit \
  && ./obj_dir/sim_enemy_unit | tee /dev/stderr | grep -qF '*** PASSED ***' \
  && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }

/* src/enemy_ctl.sv */
// **************************************************
// enemy controller
// frame tick from vblnk, sideways motion with bounce
// at both edges, and periodic fire requests
// **************************************************

`timescale 1ns/1ps

module enemy_ctl import enemy_pkg::*; (
  input  logic   pclk,
  input  logic   reset_i,
  input  level_t level_i,
  input  logic   vblnk_i,
  output pos_t   enemy_x_o,
  output logic   frame_tick_o,
  output logic   fire_req_o
);

  logic                  vblnk_d;
  logic [FIRE_CNT_W-1:0] frame_cnt;
  dir_t                  dir;
  pos_t                  x_q;
  pos_t                  step;
  pos_t                  x_right;

  assign step    = pos_t'(level_i) + pos_t'(1);  // level 0 still moves
  assign x_right = x_q + step;

  // vblnk rising edge, tick lands one cycle later
  always_ff @(posedge pclk) begin
    if (reset_i) begin
      vblnk_d      <= 1'b0;
      frame_tick_o <= 1'b0;
    end else begin
      vblnk_d      <= vblnk_i;
      frame_tick_o <= vblnk_i & ~vblnk_d;
    end
  end

  // position and direction, clamp and turn at the edges
  always_ff @(posedge pclk) begin
    if (reset_i) begin
      x_q <= ENEMY_X0;
      dir <= MOVE_RIGHT;
    end else if (frame_tick_o) begin
      case (dir)
        MOVE_RIGHT: begin
          if (x_right > X_MAX) begin
            x_q <= X_MAX;
            dir <= MOVE_LEFT;
          end else begin
            x_q <= x_right;
          end
        end
        MOVE_LEFT: begin
          if (step > x_q) begin  // would cross column 0
            x_q <= '0;
            dir <= MOVE_RIGHT;
          end else begin
            x_q <= x_q - step;
          end
        end
      endcase
    end
  end

  // every FIRE_PERIOD-th tick asks for a shot
  always_ff @(posedge pclk) begin
    if (reset_i) begin
      frame_cnt  <= '0;
      fire_req_o <= 1'b0;
    end else begin
      fire_req_o <= 1'b0;
      if (frame_tick_o) begin
        if (frame_cnt == FIRE_CNT_W'(FIRE_PERIOD - 1)) begin
          frame_cnt  <= '0;
          fire_req_o <= 1'b1;
        end else begin
          frame_cnt <= frame_cnt + 1'b1;
        end
      end
    end
  end

  assign enemy_x_o = x_q;

endmodule

/* src/enemy_missile_ctl.sv */
// **************************************************
// enemy missile controller
// launches from the enemy muzzle on a fire request
// and falls one step per frame off the bottom edge
// **************************************************

`timescale 1ns/1ps

module enemy_missile_ctl import enemy_pkg::*; (
  input  logic pclk,
  input  logic reset_i,
  input  logic frame_tick_i,
  input  logic fire_req_i,
  input  pos_t enemy_x_i,
  input  logic alive_i,
  output pos_t msl_x_o,
  output pos_t msl_y_o,
  output logic msl_on_o
);

  msl_state_t state;
  pos_t       x_q;
  pos_t       y_q;
  pos_t       y_next;
  logic       launch;
  logic       fall;

  assign launch = (state == MSL_IDLE) && fire_req_i && alive_i;
  assign fall   = (state == MSL_FLY) && frame_tick_i;
  assign y_next = y_q + MISSILE_STEP;

  always_ff @(posedge pclk) begin
    if (reset_i) begin
      state <= MSL_IDLE;
    end else begin
      case (state)
        MSL_IDLE: begin
          if (launch) begin
            state <= MSL_FLY;
          end
        end
        MSL_FLY: begin
          // keeps going even if the enemy dies meanwhile
          if (fall && (y_next >= SCREEN_H)) begin
            state <= MSL_IDLE;
          end
        end
      endcase
    end
  end

  // position only matters while flying
  always_ff @(posedge pclk) begin
    if (launch) begin
      x_q <= enemy_x_i + MSL_X_OFS;
      y_q <= ENEMY_Y + ENEMY_H;  // just under the enemy
    end else if (fall) begin
      y_q <= y_next;
    end
  end

  assign msl_x_o  = x_q;
  assign msl_y_o  = y_q;
  assign msl_on_o = (state == MSL_FLY);

endmodule

/* src/enemy_pkg.sv */
// **************************************************
// enemy package
// widths, screen and sprite constants and the state
// encodings shared by the enemy blocks
// **************************************************

package enemy_pkg;

  // meaningful widths
  typedef logic [10:0] pos_t;    // pixel coordinate or count
  typedef logic [11:0] rgb_t;    // 4 bits each of r, g, b
  typedef logic [3:0]  level_t;  // game level, sets enemy speed

  // visible area
  localparam pos_t SCREEN_W = 11'd800;
  localparam pos_t SCREEN_H = 11'd600;

  // enemy box
  localparam pos_t ENEMY_W  = 11'd32;
  localparam pos_t ENEMY_H  = 11'd24;
  localparam pos_t ENEMY_Y  = 11'd64;  // fixed top row
  localparam pos_t ENEMY_X0 = 11'd16;  // left edge after reset

  // rightmost legal left edge
  localparam pos_t X_MAX = SCREEN_W - ENEMY_W;

  // enemy missile
  localparam pos_t MISSILE_W    = 11'd4;
  localparam pos_t MISSILE_H    = 11'd12;
  localparam pos_t MISSILE_STEP = 11'd4;  // rows per frame

  // centres the missile under the enemy
  localparam pos_t MSL_X_OFS = (ENEMY_W - MISSILE_W) / 2;

  // firing cadence in frames
  localparam int FIRE_PERIOD = 8;
  localparam int FIRE_CNT_W  = $clog2(FIRE_PERIOD);

  // paint colours
  localparam rgb_t ENEMY_RGB   = 12'hF00;  // red
  localparam rgb_t MISSILE_RGB = 12'hFF0;  // yellow

  typedef enum logic {
    MOVE_RIGHT = 1'b0,
    MOVE_LEFT  = 1'b1
  } dir_t;

  typedef enum logic {
    MSL_IDLE = 1'b0,
    MSL_FLY  = 1'b1
  } msl_state_t;

endpackage

/* src/enemy_unit.sv */
// **************************************************
// enemy unit
// one enemy with its missile, overlaid onto the
// vga stream in two stages, 2 cycles of latency
// **************************************************

`timescale 1ns/1ps

module enemy_unit import enemy_pkg::*; (
  input  logic   pclk,
  input  logic   reset_i,
  input  level_t level_i,

  input  pos_t   pmsl_x_i,   // player missile point
  input  pos_t   pmsl_y_i,
  input  logic   pmsl_on_i,

  input  pos_t   vcount_i,
  input  pos_t   hcount_i,
  input  logic   vsync_i,
  input  logic   hsync_i,
  input  logic   vblnk_i,
  input  logic   hblnk_i,
  input  rgb_t   rgb_i,

  output pos_t   vcount_o,
  output pos_t   hcount_o,
  output logic   vsync_o,
  output logic   hsync_o,
  output logic   vblnk_o,
  output logic   hblnk_o,
  output rgb_t   rgb_o
);

  vga_if vga_in  ();
  vga_if vga_mid ();  // enemy stage to missile stage
  vga_if vga_out ();

  pos_t enemy_x;
  logic frame_tick;
  logic fire_req;
  logic enemy_alive;
  pos_t msl_x;
  pos_t msl_y;
  logic msl_on;

  assign vga_in.vcount = vcount_i;
  assign vga_in.hcount = hcount_i;
  assign vga_in.vsync  = vsync_i;
  assign vga_in.hsync  = hsync_i;
  assign vga_in.vblnk  = vblnk_i;
  assign vga_in.hblnk  = hblnk_i;
  assign vga_in.rgb    = rgb_i;

  enemy_ctl u_enemy_ctl (
    .pclk         (pclk),
    .reset_i      (reset_i),
    .level_i      (level_i),
    .vblnk_i      (vga_in.vblnk),
    .enemy_x_o    (enemy_x),
    .frame_tick_o (frame_tick),
    .fire_req_o   (fire_req)
  );

  hit_detect u_hit_detect (
    .pclk      (pclk),
    .reset_i   (reset_i),
    .pmsl_x_i  (pmsl_x_i),
    .pmsl_y_i  (pmsl_y_i),
    .pmsl_on_i (pmsl_on_i),
    .enemy_x_i (enemy_x),
    .alive_o   (enemy_alive)
  );

  enemy_missile_ctl u_missile_ctl (
    .pclk         (pclk),
    .reset_i      (reset_i),
    .frame_tick_i (frame_tick),
    .fire_req_i   (fire_req),
    .enemy_x_i    (enemy_x),
    .alive_i      (enemy_alive),
    .msl_x_o      (msl_x),
    .msl_y_o      (msl_y),
    .msl_on_o     (msl_on)
  );

  // enemy first, missile painted on top
  sprite_draw #(
    .SPR_W   (ENEMY_W),
    .SPR_H   (ENEMY_H),
    .SPR_RGB (ENEMY_RGB)
  ) u_draw_enemy (
    .pclk    (pclk),
    .reset_i (reset_i),
    .x_i     (enemy_x),
    .y_i     (ENEMY_Y),
    .on_i    (enemy_alive),
    .vga_in  (vga_in.snk),
    .vga_out (vga_mid.src)
  );

  sprite_draw #(
    .SPR_W   (MISSILE_W),
    .SPR_H   (MISSILE_H),
    .SPR_RGB (MISSILE_RGB)
  ) u_draw_missile (
    .pclk    (pclk),
    .reset_i (reset_i),
    .x_i     (msl_x),
    .y_i     (msl_y),
    .on_i    (msl_on),
    .vga_in  (vga_mid.snk),
    .vga_out (vga_out.src)
  );

  assign vcount_o = vga_out.vcount;
  assign hcount_o = vga_out.hcount;
  assign vsync_o  = vga_out.vsync;
  assign hsync_o  = vga_out.hsync;
  assign vblnk_o  = vga_out.vblnk;
  assign hblnk_o  = vga_out.hblnk;
  assign rgb_o    = vga_out.rgb;

endmodule

/* src/hit_detect.sv */
// **************************************************
// hit detector
// player missile against the enemy box, sticky kill
// **************************************************

`timescale 1ns/1ps

module hit_detect import enemy_pkg::*; (
  input  logic pclk,
  input  logic reset_i,
  input  pos_t pmsl_x_i,
  input  pos_t pmsl_y_i,
  input  logic pmsl_on_i,
  input  pos_t enemy_x_i,
  output logic alive_o
);

  pos_t x_last;
  logic in_x;
  logic in_y;
  logic hit;
  logic alive_q;

  // inclusive right edge
  assign x_last = enemy_x_i + ENEMY_W - pos_t'(1);

  assign in_x = (pmsl_x_i >= enemy_x_i) && (pmsl_x_i <= x_last);
  assign in_y = (pmsl_y_i >= ENEMY_Y) && (pmsl_y_i < ENEMY_Y + ENEMY_H);

  assign hit = pmsl_on_i && in_x && in_y;

  // once dead, stays dead until reset
  always_ff @(posedge pclk) begin
    if (reset_i) begin
      alive_q <= 1'b1;
    end else if (hit) begin
      alive_q <= 1'b0;
    end
  end

  assign alive_o = alive_q;

endmodule

/* src/sprite_draw.sv */
// **************************************************
// sprite overlay stage
// paints a solid rectangle onto the passing vga
// stream, one cycle of latency
// **************************************************

`timescale 1ns/1ps

module sprite_draw import enemy_pkg::*; #(
  parameter pos_t SPR_W   = ENEMY_W,
  parameter pos_t SPR_H   = ENEMY_H,
  parameter rgb_t SPR_RGB = ENEMY_RGB
) (
  input  logic      pclk,
  input  logic      reset_i,
  input  pos_t      x_i,
  input  pos_t      y_i,
  input  logic      on_i,
  vga_if.snk        vga_in,
  vga_if.src        vga_out
);

  logic in_x;
  logic in_y;
  logic paint;

  assign in_x = (vga_in.hcount >= x_i) && (vga_in.hcount < x_i + SPR_W);
  assign in_y = (vga_in.vcount >= y_i) && (vga_in.vcount < y_i + SPR_H);

  // never paint into blanking
  assign paint = on_i && in_x && in_y && !vga_in.hblnk && !vga_in.vblnk;

  always_ff @(posedge pclk) begin
    if (reset_i) begin
      vga_out.vcount <= '0;
      vga_out.hcount <= '0;
      vga_out.vsync  <= 1'b0;
      vga_out.hsync  <= 1'b0;
      vga_out.vblnk  <= 1'b0;
      vga_out.hblnk  <= 1'b0;
      vga_out.rgb    <= '0;
    end else begin
      vga_out.vcount <= vga_in.vcount;
      vga_out.hcount <= vga_in.hcount;
      vga_out.vsync  <= vga_in.vsync;
      vga_out.hsync  <= vga_in.hsync;
      vga_out.vblnk  <= vga_in.vblnk;
      vga_out.hblnk  <= vga_in.hblnk;
      vga_out.rgb    <= paint ? SPR_RGB : vga_in.rgb;
    end
  end

endmodule

/* src/vga_if.sv */
// **************************************************
// vga stream bundle
// timing counts, syncs, blanks and pixel colour
// **************************************************

`timescale 1ns/1ps

interface vga_if import enemy_pkg::*; ();

  pos_t vcount;
  pos_t hcount;
  logic vsync;
  logic hsync;
  logic vblnk;
  logic hblnk;
  rgb_t rgb;

  // driving side
  modport src (output vcount, hcount, vsync, hsync, vblnk, hblnk, rgb);

  // receiving side
  modport snk (input vcount, hcount, vsync, hsync, vblnk, hblnk, rgb);

endinterface

/* verification/enemy_unit_tb.sv */
// **************************************************
// enemy unit testbench
// short frames, reference model of the enemy and its
// missile, table of probe pixels applied in a loop
// **************************************************

`timescale 1ns/1ps

module enemy_unit_tb import enemy_pkg::*; ();

  typedef struct packed {
    int level;
    int pdx;     // player missile x, relative to enemy x
    int py;
    int pon;
    int frames;
    int mode;    // 0 probe near enemy, 1 near missile
    int dx;
    int dy;
    int exp;     // -1 model, -2 input rgb, else colour
  } row_t;

  localparam int NROWS = 25;
  localparam int NSTREAM = 24;

  logic pclk, reset_i, pmsl_on_i;
  level_t level_i;
  pos_t pmsl_x_i, pmsl_y_i, vcount_i, hcount_i, vcount_o, hcount_o;
  logic vsync_i, hsync_i, vblnk_i, hblnk_i, vsync_o, hsync_o, vblnk_o, hblnk_o;
  rgb_t rgb_i, rgb_o;

  row_t rows [NROWS];
  logic [31:0] seed;
  int errors, checks;
  // reference model state
  int m_x, m_cnt, m_mx, m_my;
  logic m_right, m_alive, m_msl;

  enemy_unit DUT (.*);

  initial begin
    pclk = 1'b0;
    forever #20 pclk = ~pclk;
  end

  function automatic rgb_t next_rgb();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[27:16];
  endfunction

  // expected pixel from the model, missile painted over enemy
  function automatic rgb_t model_rgb(pos_t h, pos_t v, rgb_t r);
    int hi, vi;
    hi = int'(h);
    vi = int'(v);
    if (m_msl && hi >= m_mx && hi < m_mx + 4 && vi >= m_my && vi < m_my + 12) begin
      return MISSILE_RGB;
    end
    if (m_alive && hi >= m_x && hi < m_x + 32 && vi >= 64 && vi < 88) return ENEMY_RGB;
    return r;
  endfunction

  task automatic model_frame(input int level);
    if (m_msl) begin
      m_my = m_my + 4;
      if (m_my >= 600) m_msl = 1'b0;  // off the bottom
    end
    if (m_right) begin
      if (m_x + level + 1 > 768) begin
        m_x = 768;
        m_right = 1'b0;
      end else m_x = m_x + level + 1;
    end else begin
      if (level + 1 > m_x) begin
        m_x = 0;
        m_right = 1'b1;
      end else m_x = m_x - level - 1;
    end
    m_cnt = m_cnt + 1;
    if (m_cnt == 8) begin
      m_cnt = 0;
      if (!m_msl && m_alive) begin  // launch from the new position
        m_msl = 1'b1;
        m_mx = m_x + 14;
        m_my = 88;
      end
    end
  endtask

  task automatic wait_vblnk_out(input logic val);
    int n;
    n = 0;
    while (vblnk_o !== val && n < 20) begin
      @(negedge pclk);
      n++;
    end
    if (vblnk_o !== val) begin
      $display("timeout at %0t ns: vblnk_o never reached %0b", $time, val);
      $display("*** FAILED ***");
      $finish;
    end
  endtask

  task automatic send_frame(input int level);
    repeat (4) begin
      @(posedge pclk);
      vblnk_i <= 1'b1;
    end
    wait_vblnk_out(1'b1);
    @(posedge pclk);
    vblnk_i <= 1'b0;
    wait_vblnk_out(1'b0);
    repeat (3) @(posedge pclk);  // tick, fire and launch settle
    model_frame(level);
  endtask

  task automatic probe_pixel(input pos_t h, input pos_t v, input int exp, output logic ok);
    rgb_t r, want;
    r = next_rgb();
    @(posedge pclk);
    hcount_i <= h;
    vcount_i <= v;
    rgb_i    <= r;
    @(posedge pclk);
    hcount_i <= '0;
    vcount_i <= '0;
    rgb_i    <= '0;
    @(posedge pclk);
    @(negedge pclk);
    want = (exp == -1) ? model_rgb(h, v, r) : (exp == -2) ? r : rgb_t'(exp);
    ok = 1'b1;
    checks++;
    assert (rgb_o == want) else begin
      $display("** Error at %0t ns: rgb_o = %h, expected %h", $time, rgb_o, want);
      ok = 1'b0;
    end
    assert ({hcount_o, vcount_o} == {h, v}) else begin
      $display("** Error at %0t ns: hcount_o/vcount_o = %0d/%0d, expected %0d/%0d",
               $time, hcount_o, vcount_o, h, v);
      ok = 1'b0;
    end
  endtask

  // random pixels straight through, 2 cycle latency
  task automatic stream_check();
    logic [25:0] tim [NSTREAM];  // vcount, hcount, vsync, hsync, vblnk, hblnk
    rgb_t        col [NSTREAM];
    int          bad;
    bad = 0;
    for (int i = 0; i < NSTREAM + 2; i++) begin
      @(posedge pclk);
      if (i < NSTREAM) begin
        col[i] = next_rgb();
        if (i % 2 == 1) tim[i] = {11'd70, pos_t'(16 + i), seed[3:2], 2'b01};  // hblnk over enemy
        else tim[i] = {pos_t'(300 + i), pos_t'(seed[10:0]), seed[3:2], 2'b00};
        {vcount_i, hcount_i, vsync_i, hsync_i, vblnk_i, hblnk_i} <= tim[i];
        rgb_i <= col[i];
      end
      @(negedge pclk);
      if (i >= 2) begin
        checks++;
        assert ({vcount_o, hcount_o, vsync_o, hsync_o, vblnk_o, hblnk_o} == tim[i-2]) else begin
          $display("** Error at %0t ns: timing outputs = %h, expected %h", $time,
                   {vcount_o, hcount_o, vsync_o, hsync_o, vblnk_o, hblnk_o}, tim[i-2]);
          bad++;
        end
        assert (rgb_o == col[i-2]) else begin
          $display("** Error at %0t ns: rgb_o = %h, expected %h", $time, rgb_o, col[i-2]);
          bad++;
        end
      end
    end
    @(posedge pclk);
    {vcount_i, hcount_i, vsync_i, hsync_i, vblnk_i, hblnk_i, rgb_i} <= '0;
    errors += bad;
    $display("pass-through: %s", (bad == 0) ? "ok" : "mismatch");
  endtask

  initial begin
    logic ok;
    seed = 32'd46614;
    errors = 0;
    checks = 0;
    {m_x, m_cnt, m_right, m_alive, m_msl} = {32'd16, 32'd0, 1'b1, 1'b1, 1'b0};
    {m_mx, m_my} = '0;
    reset_i = 1'b1;
    level_i = '0;
    {pmsl_x_i, pmsl_y_i, pmsl_on_i} = '0;
    // busy stream while in reset, outputs must still read 0
    {vcount_i, hcount_i, vsync_i, hsync_i, vblnk_i, hblnk_i} = {11'd70, 11'd20, 4'b1111};
    rgb_i = 12'hABC;
    rows = '{
      '{0, 0, 0, 0, 0, 0, 0, 0, 'hF00}, '{0, 0, 0, 0, 0, 0, 31, 23, 'hF00},
      '{0, 0, 0, 0, 0, 0, -1, 0, -2}, '{0, 0, 0, 0, 0, 0, 32, 0, -2},
      '{0, 0, 0, 0, 0, 0, 0, 24, -2}, '{0, 0, 0, 0, 5, 0, 0, 0, -1},
      '{0, 0, 0, 0, 0, 0, -1, 0, -1}, '{3, 0, 0, 0, 40, 0, 0, 5, -1},
      '{3, 0, 0, 0, 0, 0, -1, 5, -1}, '{15, 0, 0, 0, 60, 0, 0, 10, -1},
      '{15, 0, 0, 0, 0, 0, -1, 10, -1}, '{15, 0, 0, 0, 60, 0, 0, 0, -1},
      '{15, 0, 0, 0, 0, 0, -1, 0, -1}, '{0, 0, 0, 0, 1, 1, 0, 0, 'hFF0},
      '{0, 0, 0, 0, 0, 1, 3, 11, 'hFF0}, '{0, 0, 0, 0, 0, 1, 4, 0, -2},
      '{0, 0, 0, 0, 0, 1, 0, 12, -2}, '{0, 0, 0, 0, 3, 1, 0, 0, -1},
      '{0, -1, 64, 1, 0, 0, 0, 0, 'hF00}, '{0, 0, 64, 0, 0, 0, 0, 0, 'hF00},
      '{0, 32, 70, 1, 0, 0, 0, 0, 'hF00}, '{0, 10, 88, 1, 0, 0, 0, 0, 'hF00},
      '{0, 31, 87, 1, 1, 0, 0, 0, -2}, '{0, 0, 0, 0, 94, 1, 0, 0, -2},
      '{0, 0, 0, 0, 0, 0, 14, 24, -2}  // dead enemy on a fire frame, no new shot
    };
    repeat (5) @(posedge pclk);
    reset_i <= 1'b0;
    {vcount_i, hcount_i, vsync_i, hsync_i, vblnk_i, hblnk_i, rgb_i} <= '0;
    @(negedge pclk);
    ok = 1'b1;
    checks++;
    assert ({vcount_o, hcount_o, vsync_o, hsync_o, vblnk_o, hblnk_o, rgb_o} == '0) else begin
      $display("** Error at %0t ns: outputs in reset = %h, expected 0", $time,
               {vcount_o, hcount_o, vsync_o, hsync_o, vblnk_o, hblnk_o, rgb_o});
      ok = 1'b0;
    end
    if (!ok) errors++;
    $display("reset: %s", ok ? "ok" : "mismatch");
    stream_check();
    for (int i = 0; i < NROWS; i++) begin
      @(posedge pclk);
      level_i   <= level_t'(rows[i].level);
      pmsl_x_i  <= pos_t'(m_x + rows[i].pdx);
      pmsl_y_i  <= pos_t'(rows[i].py);
      pmsl_on_i <= rows[i].pon[0];
      @(posedge pclk);
      pmsl_on_i <= 1'b0;
      if (rows[i].pon != 0 && rows[i].pdx >= 0 && rows[i].pdx < 32
          && rows[i].py >= 64 && rows[i].py < 88) m_alive = 1'b0;
      repeat (rows[i].frames) send_frame(rows[i].level);
      if (rows[i].mode == 0) probe_pixel(pos_t'(m_x + rows[i].dx), pos_t'(64 + rows[i].dy),
                                         rows[i].exp, ok);
      else probe_pixel(pos_t'(m_mx + rows[i].dx), pos_t'(m_my + rows[i].dy), rows[i].exp, ok);
      if (!ok) errors++;
      $display("row %0d: %s (enemy x %0d)", i, ok ? "ok" : "mismatch", m_x);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
